// File: common/dcache_pkg.sv
// geometry of the 1 KB direct-mapped data cache, physical byte addresses only
// byte lanes are little-endian, sel bit i covers bits 8i+7..8i
`default_nettype none

package dcache_pkg;

	// --------------------
	// geometry
	localparam int ADDR_W     = 32;
	localparam int WORD_W     = 32;
	localparam int LINE_WORDS = 4;
	localparam int LINE_W     = WORD_W * LINE_WORDS;  // 128
	localparam int OFFSET_W   = 4;                    // byte offset in line
	localparam int INDEX_W    = 6;                    // 64 lines
	localparam int NUM_LINES  = 2 ** INDEX_W;
	localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
	localparam int SEL_W      = WORD_W / 8;
	localparam int WORD_SEL_W = 2;                    // word within line
	localparam int LINE_NUM_W = ADDR_W - OFFSET_W;    // 28

	// --------------------
	// refill engine states
	localparam logic [2:0] ST_SWEEP = 3'd0;  // clearing valid bits after reset
	localparam logic [2:0] ST_IDLE  = 3'd1;
	localparam logic [2:0] ST_WB    = 3'd2;  // dirty victim out
	localparam logic [2:0] ST_FILL  = 3'd3;  // new line in
	localparam logic [2:0] ST_WRITE = 3'd4;  // line buffer into arrays

	// one address, two decodings
	typedef union packed {
		struct packed {
			logic [TAG_W-1:0]               tag;
			logic [INDEX_W-1:0]             index;
			logic [WORD_SEL_W-1:0]          word;
			logic [OFFSET_W-WORD_SEL_W-1:0] byte_off;
		} lk;    // lookup view
		struct packed {
			logic [LINE_NUM_W-1:0] num;
			logic [OFFSET_W-1:0]   off;
		} ln;    // line view, for bus addresses
	} cache_addr_t;

endpackage

`default_nettype wire

// File: dcache/dcache_lookup.sv
// two-stage lookup: ram read, then hit/replay decision registered at k+2
// a replayed request must come back unchanged; stores allocate on miss
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup (
	input  logic                              gclk,
	input  logic                              rst,
	input  logic                              req_valid,
	input  logic                              req_we,
	input  dcache_pkg::cache_addr_t           req_addr,
	input  logic [dcache_pkg::WORD_W-1:0]     req_wdata,
	input  logic [dcache_pkg::SEL_W-1:0]      req_sel,
	output logic                              rsp_valid,
	output logic                              rsp_replay,
	output logic [dcache_pkg::WORD_W-1:0]     rsp_rdata,
	output logic [dcache_pkg::INDEX_W-1:0]    cpu_index,
	input  logic [dcache_pkg::TAG_W-1:0]      cpu_rd_tag,
	input  logic                              cpu_rd_valid,
	input  logic                              cpu_rd_dirty,
	input  logic [dcache_pkg::LINE_W-1:0]     cpu_rd_line,
	output logic                              cpu_we_tag,
	output logic [dcache_pkg::LINE_WORDS-1:0] cpu_we_word,
	output logic [dcache_pkg::INDEX_W-1:0]    cpu_wr_index,
	output logic [dcache_pkg::TAG_W-1:0]      cpu_wr_tag,
	output logic                              cpu_wr_dirty,
	output logic [dcache_pkg::LINE_W-1:0]     cpu_wr_line,
	output logic                              miss_start,
	output dcache_pkg::cache_addr_t           miss_addr,
	output logic [dcache_pkg::TAG_W-1:0]      victim_tag,
	output logic                              victim_dirty,
	output logic [dcache_pkg::LINE_W-1:0]     victim_line,
	input  logic                              miss_busy,
	input  logic [dcache_pkg::INDEX_W-1:0]    miss_index
);
	import dcache_pkg::*;

	// stage 1, request only
	logic               s1_valid;
	logic               s1_we;
	cache_addr_t        s1_addr;
	logic [WORD_W-1:0]  s1_wdata;
	logic [SEL_W-1:0]   s1_sel;
	// stage 2, request plus ram output
	logic               s2_valid;
	logic               s2_we;
	cache_addr_t        s2_addr;
	logic [WORD_W-1:0]  s2_wdata;
	logic [SEL_W-1:0]   s2_sel;
	logic [TAG_W-1:0]   s2_tag;
	logic               s2_vbit;
	logic               s2_dirty;
	logic [LINE_W-1:0]  s2_line;
	// indices written by store hits in the last two cycles
	logic [1:0]         hist_we;
	logic [INDEX_W-1:0] hist_idx [2];
	logic               busy_q;
	logic               swept;  // valid bits are trustworthy
	logic               hit;
	logic               locked;
	logic               raw_hazard;
	logic               replay;
	logic               store_hit;
	logic [WORD_W-1:0]  rd_word;
	logic [WORD_W-1:0]  merged;

	function automatic logic [WORD_W-1:0] merge_bytes(input logic [WORD_W-1:0] old_w,
			input logic [WORD_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		logic [WORD_W-1:0] res;
		res = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];  // lane b
		end
		return res;
	endfunction

	assign cpu_index = req_addr.lk.index;  // ram read in the issue cycle

	// --------------------
	// decision on stage 2
	always_comb begin
		rd_word    = s2_line[s2_addr.lk.word*WORD_W +: WORD_W];
		merged     = merge_bytes(rd_word, s2_wdata, s2_sel);
		hit        = s2_vbit && (s2_tag == s2_addr.lk.tag);
		locked     = miss_busy && (miss_index == s2_addr.lk.index);
		raw_hazard = (hist_we[0] && hist_idx[0] == s2_addr.lk.index)
			|| (hist_we[1] && hist_idx[1] == s2_addr.lk.index);  // ram read was stale
		replay     = !swept || raw_hazard || locked || !hit;  // every miss replays
		store_hit  = s2_valid && s2_we && !replay;
		miss_start = s2_valid && swept && !raw_hazard && !miss_busy && !hit;

		cpu_we_word = '0;
		cpu_we_word[s2_addr.lk.word] = store_hit;
		cpu_wr_line = s2_line;
		cpu_wr_line[s2_addr.lk.word*WORD_W +: WORD_W] = merged;
	end

	assign cpu_we_tag   = store_hit;
	assign cpu_wr_index = s2_addr.lk.index;
	assign cpu_wr_tag   = s2_addr.lk.tag;
	assign cpu_wr_dirty = 1'b1;             // store hit leaves the line dirty
	assign miss_addr    = s2_addr;
	assign victim_tag   = s2_tag;
	assign victim_dirty = s2_vbit && s2_dirty;
	assign victim_line  = s2_line;

	// --------------------
	// control state
	always_ff @(posedge gclk) begin
		if (rst) begin
			s1_valid   <= 1'b0;
			s2_valid   <= 1'b0;
			rsp_valid  <= 1'b0;
			rsp_replay <= 1'b0;
			hist_we    <= '0;
			busy_q     <= 1'b0;
			swept      <= 1'b0;
		end else begin
			s1_valid   <= req_valid;
			s2_valid   <= s1_valid;
			rsp_valid  <= s2_valid && !replay;
			rsp_replay <= s2_valid && replay;
			hist_we    <= {hist_we[0], store_hit};
			busy_q     <= miss_busy;
			if (busy_q && !miss_busy)
				swept <= 1'b1;  // first fall of busy is the end of the sweep
		end
	end

	// payload
	always_ff @(posedge gclk) begin
		s1_we       <= req_we;
		s1_addr     <= req_addr;
		s1_wdata    <= req_wdata;
		s1_sel      <= req_sel;
		s2_we       <= s1_we;
		s2_addr     <= s1_addr;
		s2_wdata    <= s1_wdata;
		s2_sel      <= s1_sel;
		s2_tag      <= cpu_rd_tag;
		s2_vbit     <= cpu_rd_valid;
		s2_dirty    <= cpu_rd_dirty;
		s2_line     <= cpu_rd_line;
		rsp_rdata   <= rd_word;     // old word for stores, ignored there
		hist_idx[0] <= s2_addr.lk.index;
		hist_idx[1] <= hist_idx[0];
	end

endmodule

`default_nettype wire

// File: dcache/dcache_ram.sv
// tag, valid, dirty and data arrays, one cycle registered read
// same-index writes in one cycle: the fill port wins
`timescale 1ns/1ps
`default_nettype none

module dcache_ram (
	input  logic                              gclk,
	input  logic [dcache_pkg::INDEX_W-1:0]    cpu_index,
	output logic [dcache_pkg::TAG_W-1:0]      cpu_rd_tag,
	output logic                              cpu_rd_valid,
	output logic                              cpu_rd_dirty,
	output logic [dcache_pkg::LINE_W-1:0]     cpu_rd_line,
	input  logic                              cpu_we_tag,
	input  logic [dcache_pkg::LINE_WORDS-1:0] cpu_we_word,
	input  logic [dcache_pkg::INDEX_W-1:0]    cpu_wr_index,
	input  logic [dcache_pkg::TAG_W-1:0]      cpu_wr_tag,
	input  logic                              cpu_wr_dirty,
	input  logic [dcache_pkg::LINE_W-1:0]     cpu_wr_line,
	input  logic                              fill_we,
	input  logic                              fill_clear,
	input  logic [dcache_pkg::INDEX_W-1:0]    fill_index,
	input  logic [dcache_pkg::TAG_W-1:0]      fill_tag,
	input  logic [dcache_pkg::LINE_W-1:0]     fill_line
);
	import dcache_pkg::*;

	logic [TAG_W-1:0] tag_mem   [NUM_LINES];
	logic             valid_mem [NUM_LINES];
	logic             dirty_mem [NUM_LINES];
	logic             fill_hit;  // fill port writes the line being read

	// the read sees a fill written on the same edge, so a line never
	// comes back stale after the lock drops
	assign fill_hit = (fill_we | fill_clear) && (fill_index == cpu_index);

	// --------------------
	// tag side
	always_ff @(posedge gclk) begin
		if (cpu_we_tag) begin
			tag_mem[cpu_wr_index]   <= cpu_wr_tag;
			valid_mem[cpu_wr_index] <= 1'b1;
			dirty_mem[cpu_wr_index] <= cpu_wr_dirty;
		end
		if (fill_we) begin  // after cpu write, so fill wins
			tag_mem[fill_index]   <= fill_tag;
			valid_mem[fill_index] <= 1'b1;
			dirty_mem[fill_index] <= 1'b0;  // filled clean
		end
		if (fill_clear) begin
			valid_mem[fill_index] <= 1'b0;
			dirty_mem[fill_index] <= 1'b0;
		end
		cpu_rd_tag   <= (fill_hit && fill_we) ? fill_tag : tag_mem[cpu_index];
		cpu_rd_valid <= fill_hit ? fill_we : valid_mem[cpu_index];
		cpu_rd_dirty <= fill_hit ? 1'b0 : dirty_mem[cpu_index];
	end

	// --------------------
	// data side, one array per word
	for (genvar w = 0; w < LINE_WORDS; w++) begin : g_word
		logic [WORD_W-1:0] mem [NUM_LINES];
		logic [WORD_W-1:0] rd_word;

		always_ff @(posedge gclk) begin
			if (cpu_we_word[w])
				mem[cpu_wr_index] <= cpu_wr_line[w*WORD_W +: WORD_W];
			if (fill_we)
				mem[fill_index] <= fill_line[w*WORD_W +: WORD_W];
			rd_word <= (fill_hit && fill_we) ? fill_line[w*WORD_W +: WORD_W] : mem[cpu_index];
		end

		assign cpu_rd_line[w*WORD_W +: WORD_W] = rd_word;
	end

endmodule

`default_nettype wire

// File: dcache/dcache_refill.sv
// single miss-status entry plus Wishbone classic master, one word per bus cycle
// dirty victim goes out words 0..3 before the fill reads words 0..3
`timescale 1ns/1ps
`default_nettype none

module dcache_refill (
	input  logic                           gclk,
	input  logic                           rst,
	input  logic                           miss_start,
	input  dcache_pkg::cache_addr_t        miss_addr,
	input  logic [dcache_pkg::TAG_W-1:0]   victim_tag,
	input  logic                           victim_dirty,
	input  logic [dcache_pkg::LINE_W-1:0]  victim_line,
	output logic                           miss_busy,
	output logic [dcache_pkg::INDEX_W-1:0] miss_index,
	output logic                           fill_we,
	output logic                           fill_clear,
	output logic [dcache_pkg::INDEX_W-1:0] fill_index,
	output logic [dcache_pkg::TAG_W-1:0]   fill_tag,
	output logic [dcache_pkg::LINE_W-1:0]  fill_line,
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic                           wb_we,
	output logic [dcache_pkg::ADDR_W-1:0]  wb_adr,
	output logic [dcache_pkg::WORD_W-1:0]  wb_dat_o,
	output logic [dcache_pkg::SEL_W-1:0]   wb_sel,
	input  logic [dcache_pkg::WORD_W-1:0]  wb_dat_i,
	input  logic                           wb_ack
);
	import dcache_pkg::*;

	logic [2:0]            state;
	logic [2:0]            state_nx;
	logic [INDEX_W-1:0]    sweep_idx;
	logic [WORD_SEL_W-1:0] word_cnt;
	cache_addr_t           m_addr;    // miss-status entry, the locked line
	logic [TAG_W-1:0]      v_tag;
	logic [LINE_W-1:0]     v_line;    // captured victim
	logic [LINE_W-1:0]     line_buf;  // fill assembly
	logic [LINE_NUM_W-1:0] bus_line;
	cache_addr_t           bus_addr;
	logic                  last_ack;

	assign last_ack = wb_cyc && wb_ack && (&word_cnt);  // word 3 acked

	// --------------------
	// next state
	always_comb begin
		state_nx = state;
		case (state)
			ST_SWEEP: if (&sweep_idx) state_nx = ST_IDLE;
			ST_IDLE:  if (miss_start) state_nx = victim_dirty ? ST_WB : ST_FILL;
			ST_WB:    if (last_ack) state_nx = ST_FILL;
			ST_FILL:  if (last_ack) state_nx = ST_WRITE;
			ST_WRITE: state_nx = ST_IDLE;
			default:  state_nx = ST_IDLE;
		endcase
	end

	// write-back targets the victim's line, fill the missed one
	always_comb begin
		bus_line        = (state == ST_WB) ? {v_tag, m_addr.lk.index} : m_addr.ln.num;
		bus_addr.ln.num = bus_line;
		bus_addr.ln.off = {word_cnt, 2'b00};
	end

	// --------------------
	// control
	always_ff @(posedge gclk) begin
		if (rst) begin
			state     <= ST_SWEEP;
			sweep_idx <= '0;
			word_cnt  <= '0;
			wb_cyc    <= 1'b0;
			miss_busy <= 1'b0;
		end else begin
			state     <= state_nx;
			miss_busy <= (state_nx != ST_IDLE) || (state == ST_WRITE);  // one cycle past the write
			if (state == ST_SWEEP)
				sweep_idx <= sweep_idx + 1'b1;
			if (wb_cyc) begin
				if (wb_ack) begin
					wb_cyc   <= 1'b0;  // drop right after ack
					word_cnt <= word_cnt + 1'b1;
				end
			end else if (state == ST_WB || state == ST_FILL) begin
				wb_cyc <= 1'b1;
			end
		end
	end

	// payload, bus fields only load while the bus is idle
	always_ff @(posedge gclk) begin
		if (state == ST_IDLE && miss_start) begin
			m_addr <= miss_addr;
			v_tag  <= victim_tag;
			v_line <= victim_line;
		end
		if (!wb_cyc) begin
			wb_adr   <= bus_addr;
			wb_dat_o <= v_line[word_cnt*WORD_W +: WORD_W];
			wb_we    <= (state == ST_WB);
		end
		if (state == ST_FILL && wb_cyc && wb_ack)
			line_buf[word_cnt*WORD_W +: WORD_W] <= wb_dat_i;
	end

	assign wb_stb     = wb_cyc;  // classic, stb follows cyc
	assign wb_sel     = '1;      // whole words only
	assign miss_index = m_addr.lk.index;
	assign fill_we    = (state == ST_WRITE);
	assign fill_clear = (state == ST_SWEEP);
	assign fill_index = fill_clear ? sweep_idx : m_addr.lk.index;
	assign fill_tag   = m_addr.lk.tag;
	assign fill_line  = line_buf;

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
// data cache top: one requester, replay is the only back-pressure
// memory side is a Wishbone classic master, one word per bus cycle
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  logic                           gclk,
	input  logic                           rst,
	input  logic                           req_valid,
	input  logic                           req_we,
	input  dcache_pkg::cache_addr_t        req_addr,
	input  logic [dcache_pkg::WORD_W-1:0]  req_wdata,
	input  logic [dcache_pkg::SEL_W-1:0]   req_sel,
	output logic                           rsp_valid,
	output logic                           rsp_replay,
	output logic [dcache_pkg::WORD_W-1:0]  rsp_rdata,
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic                           wb_we,
	output logic [dcache_pkg::ADDR_W-1:0]  wb_adr,
	output logic [dcache_pkg::WORD_W-1:0]  wb_dat_o,
	output logic [dcache_pkg::SEL_W-1:0]   wb_sel,
	input  logic [dcache_pkg::WORD_W-1:0]  wb_dat_i,
	input  logic                           wb_ack
);
	import dcache_pkg::*;

	// --------------------
	// lookup <-> ram
	logic [INDEX_W-1:0]    cpu_index;
	logic [TAG_W-1:0]      cpu_rd_tag;
	logic                  cpu_rd_valid;
	logic                  cpu_rd_dirty;
	logic [LINE_W-1:0]     cpu_rd_line;
	logic                  cpu_we_tag;
	logic [LINE_WORDS-1:0] cpu_we_word;
	logic [INDEX_W-1:0]    cpu_wr_index;
	logic [TAG_W-1:0]      cpu_wr_tag;
	logic                  cpu_wr_dirty;
	logic [LINE_W-1:0]     cpu_wr_line;

	// lookup <-> refill
	logic                  miss_start;
	cache_addr_t           miss_addr;
	logic [TAG_W-1:0]      victim_tag;
	logic                  victim_dirty;
	logic [LINE_W-1:0]     victim_line;
	logic                  miss_busy;
	logic [INDEX_W-1:0]    miss_index;

	// refill -> ram
	logic                  fill_we;
	logic                  fill_clear;
	logic [INDEX_W-1:0]    fill_index;
	logic [TAG_W-1:0]      fill_tag;
	logic [LINE_W-1:0]     fill_line;

	dcache_lookup u_lookup (.*);
	dcache_ram    u_ram    (.*);
	dcache_refill u_refill (.*);

endmodule

`default_nettype wire

// File: list.f
common/dcache_pkg.sv
hw/dcache_top.sv
dcache/dcache_ram.sv
dcache/dcache_lookup.sv
dcache/dcache_refill.sv
testbench/tb_wb_memory.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
# compile and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dcache -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
	exit 0
fi
exit 1

// File: testbench/tb_dcache.sv
// dcache testbench with 16-bit LFSR stimulus and a word model of the backing memory
// all addresses stay below 4 KB so the model and the memory cover them
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam logic [31:0] FILL_XOR = 32'h5a3c_96e1;
	localparam int RANDOM_OPS  = 300;
	localparam int NUM_REQ     = 12 + RANDOM_OPS;  // 1 cold, 2 store, 2 evict, 7 under miss
	localparam int CYCLE_LIMIT = 200 * NUM_REQ;

	logic              gclk;
	logic              rst;
	logic              req_valid;
	logic              req_we;
	cache_addr_t       req_addr;
	logic [WORD_W-1:0] req_wdata;
	logic [SEL_W-1:0]  req_sel;
	logic              rsp_valid;
	logic              rsp_replay;
	logic [WORD_W-1:0] rsp_rdata;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	logic [ADDR_W-1:0] wb_adr;
	logic [WORD_W-1:0] wb_dat_o;
	logic [SEL_W-1:0]  wb_sel;
	logic [WORD_W-1:0] wb_dat_i;
	logic              wb_ack;

	logic [WORD_W-1:0] model [1024];   // expected memory contents
	logic              bus_log [$];    // one entry per acked word with 1 for a write
	logic [15:0]       lfsr;
	int                cycles       = 0;
	int                checks       = 0;
	int                errors       = 0;
	int                test_errors  = 0;
	int                tests_passed = 0;
	int                tests_failed = 0;

	dcache_top dut (.*);

	tb_wb_memory #(.FILL_XOR(FILL_XOR)) u_mem (
		.gclk  (gclk),
		.rst   (rst),
		.cyc   (wb_cyc),
		.stb   (wb_stb),
		.we    (wb_we),
		.adr   (wb_adr),
		.dat_i (wb_dat_o),
		.sel   (wb_sel),
		.dat_o (wb_dat_i),
		.ack   (wb_ack)
	);

	initial begin
		gclk = 1'b0;
		forever #50 gclk = ~gclk;
	end

	// bus monitor logs the order of write-back and fill words
	always @(posedge gclk) begin
		if (wb_cyc && wb_stb && wb_ack)
			bus_log.push_back(wb_we);
	end

	always @(posedge gclk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, a request never completed", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// --------------------
	// helpers
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};  // one step per bit
		end
	endtask

	// little-endian lanes with sel bit i over bits 8i+7..8i
	function automatic logic [31:0] store_merge(input logic [31:0] old_w,
			input logic [31:0] data, input logic [3:0] sel);
		logic [31:0] mask;
		for (int i = 0; i < 4; i++)
			mask[i*8 +: 8] = {8{sel[i]}};
		return (old_w & ~mask) | (data & mask);
	endfunction

	function automatic int count_bus_ops(input int from, input logic we_val);
		int n;
		n = 0;
		for (int i = from; i < bus_log.size(); i++) begin
			if (bus_log[i] == we_val)
				n++;
		end
		return n;
	endfunction

	task automatic flag_error(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// one request from a falling edge with the answer due two edges after sampling
	task automatic send_request(input logic we, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] sel,
			output bit got, output logic [31:0] rdata);
		int lat;
		req_valid = 1'b1;
		req_we    = we;
		req_addr  = addr;
		req_wdata = wdata;
		req_sel   = sel;
		@(negedge gclk);  // sampled
		req_valid = 1'b0;
		lat = 0;
		do begin
			@(negedge gclk);
			lat++;
		end while (!rsp_valid && !rsp_replay && lat < 4);
		got   = rsp_valid && !rsp_replay;
		rdata = rsp_rdata;
		checks++;
		if (lat != 2 || (rsp_valid && rsp_replay))
			flag_error($sformatf("request to %h answered %0d cycles after issue, valid %b replay %b",
				addr, lat, rsp_valid, rsp_replay));
	endtask

	// reissue unchanged until served, then check or update the model
	task automatic access_checked(input string name, input logic we, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] sel, output int tries);
		bit          got;
		logic [31:0] rdata;
		tries = 0;
		got   = 1'b0;
		while (!got) begin
			send_request(we, addr, wdata, sel, got, rdata);
			tries++;
		end
		if (we)
			model[addr[11:2]] = store_merge(model[addr[11:2]], wdata, sel);
		else
			check_value(name, model[addr[11:2]], rdata);
	endtask

	// --------------------
	// tests
	initial begin
		int          tries;
		int          start;
		bit          got;
		bit          order_ok;
		logic        we_r;
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [31:0] wdata_r;
		logic [3:0]  sel_r;
		logic [31:0] rdata;
		logic [31:0] hum_addr [5];
		rst       = 1'b1;
		req_valid = 1'b0;
		req_we    = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		req_sel   = '0;
		lfsr      = 16'd76;
		for (int i = 0; i < 1024; i++)
			model[i] = i ^ FILL_XOR;
		repeat (3) @(posedge gclk);
		@(negedge gclk);
		rst = 1'b0;

		// quiet outputs while the sweep still runs
		for (int c = 0; c < 10; c++) begin
			@(negedge gclk);
			check_value("reset_quiet", 32'd0, {29'd0, rsp_valid, rsp_replay, wb_cyc});
		end
		finish_test("reset");

		start = bus_log.size();
		access_checked("cold_load", 1'b0, 32'h0000_0040, 32'd0, 4'h0, tries);
		if (tries < 2)
			flag_error("cold load was served without a replay");
		check_value("cold_load_reads", 32'd4, count_bus_ops(start, 1'b0));
		check_value("cold_load_writes", 32'd0, count_bus_ops(start, 1'b1));
		finish_test("cold_load");

		// mask with both kept and replaced lanes
		do begin
			take_bits(4, rnd);
			sel_r = rnd[3:0];
		end while (sel_r == 4'h0 || sel_r == 4'hf);
		take_bits(32, wdata_r);
		access_checked("byte_store", 1'b1, 32'h0000_0048, wdata_r, sel_r, tries);
		access_checked("byte_store_load", 1'b0, 32'h0000_0048, 32'd0, 4'h0, tries);
		finish_test("byte_store");

		// index 8 tag 0 made dirty and then evicted by tag 1
		take_bits(32, wdata_r);
		access_checked("evict_store", 1'b1, 32'h0000_0084, wdata_r, 4'hf, tries);
		start = bus_log.size();
		access_checked("evict_load", 1'b0, 32'h0000_0484, 32'd0, 4'h0, tries);
		check_value("evict_writes", 32'd4, count_bus_ops(start, 1'b1));
		check_value("evict_reads", 32'd4, count_bus_ops(start, 1'b0));
		order_ok = 1'b1;
		for (int i = start; i < bus_log.size(); i++) begin
			if (bus_log[i] != (i - start < 4))
				order_ok = 1'b0;
		end
		if (!order_ok)
			flag_error("dirty eviction did not write back all 4 words before the fill");
		check_value("evict_memory", model[32'h84 >> 2], u_mem.mem[32'h84 >> 2]);
		finish_test("dirty_evict");

		// miss on index 8 locks the resident tag 1 line
		// line 0x40 is read back to back under the miss
		hum_addr = '{32'h40, 32'h44, 32'h48, 32'h4c, 32'h480};
		send_request(1'b0, 32'h0000_0080, 32'd0, 4'h0, got, rdata);
		check_value("miss_replay", 32'd0, {31'd0, got});
		for (int c = 0; c < 8; c++) begin
			if (c >= 7) begin
				check_value("locked_replay", 32'd1, {31'd0, rsp_replay});
			end else if (c >= 3) begin
				check_value("hit_under_miss_valid", 32'd1, {31'd0, rsp_valid});
				check_value("hit_under_miss_data", model[hum_addr[c-3][11:2]], rsp_rdata);
			end
			if (c < 5) begin
				req_valid = 1'b1;
				req_we    = 1'b0;
				req_addr  = hum_addr[c];
			end else begin
				req_valid = 1'b0;
			end
			@(negedge gclk);
		end
		access_checked("miss_line", 1'b0, 32'h0000_0080, 32'd0, 4'h0, tries);
		finish_test("hit_under_miss");

		// 4 tags x 8 indices x 4 words
		for (int n = 0; n < RANDOM_OPS; n++) begin
			take_bits(1, rnd);
			we_r = rnd[0];
			take_bits(7, rnd);
			addr = {20'd0, rnd[6:5], 3'd0, rnd[4:2], rnd[1:0], 2'b00};
			take_bits(32, wdata_r);
			take_bits(4, rnd);
			sel_r = rnd[3:0];
			access_checked("random", we_r, addr, wdata_r, sel_r, tries);
		end
		finish_test("random_mix");

		$display("tests passed %0d failed %0d, checks %0d, errors %0d",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_wb_memory.sv
// Wishbone classic slave memory, 1K words, ack one cycle after stb
// only adr[11:2] decodes, so the cache traffic must stay below 4 KB
`timescale 1ns/1ps
`default_nettype none

module tb_wb_memory #(
	parameter logic [31:0] FILL_XOR = 32'h5a3c_96e1  // preload is word address ^ this
) (
	input  logic        gclk,
	input  logic        rst,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [31:0] adr,
	input  logic [31:0] dat_i,
	input  logic [3:0]  sel,
	output logic [31:0] dat_o,
	output logic        ack
);
	logic [31:0] mem [1024];
	logic [9:0]  word_adr;

	assign word_adr = adr[11:2];  // byte address to word

	initial begin
		for (int i = 0; i < 1024; i++)
			mem[i] = i ^ FILL_XOR;
		ack   = 1'b0;
		dat_o = '0;
	end

	// --------------------
	// one wait cycle per word, write and read both land as ack rises
	always @(posedge gclk) begin
		if (rst) begin
			ack <= 1'b0;
		end else begin
			ack <= cyc && stb && !ack;  // ack for a single cycle
			if (cyc && stb && !ack) begin
				dat_o <= mem[word_adr];
				if (we) begin
					for (int b = 0; b < 4; b++) begin
						if (sel[b])
							mem[word_adr][b*8 +: 8] <= dat_i[b*8 +: 8];  // lane b
					end
				end
			end
		end
	end

endmodule

`default_nettype wire
